/* common/dispatchPkg.sv */
//------------------------------------------------------------
// shared definitions for the dispatch stage
// group width, checkpoint and register field widths
// back-end structure sizes and their count widths
// renamed, issue, active-list and LSQ packet structs
//------------------------------------------------------------
package dispatchPkg;

  localparam int DISPATCH_WIDTH      = 4;   // instructions per group
  localparam int DISPATCH_WIDTH_LOG  = $clog2(DISPATCH_WIDTH + 1);  // holds 0..4

  // branch checkpoints
  localparam int CHECKPOINTS         = 8;
  localparam int CHECKPOINTS_LOG     = 3;

  // register and instruction fields
  localparam int SIZE_PHYSICAL_LOG   = 7;
  localparam int SIZE_RMT_LOG        = 5;   // logical register id
  localparam int SIZE_PC             = 32;
  localparam int SIZE_IMMEDIATE      = 16;
  localparam int SIZE_OPCODE         = 8;
  localparam int INST_TYPES_LOG      = 2;
  localparam int LDST_TYPES_LOG      = 2;
  localparam int SIZE_CTI_LOG        = 2;

  // back-end structures, each count port is one bit wider than its log
  localparam int SIZE_LSQ            = 16;
  localparam int SIZE_LSQ_LOG        = 4;
  localparam int SIZE_ISSUEQ         = 32;
  localparam int SIZE_ISSUEQ_LOG     = 5;
  localparam int SIZE_ACTIVELIST     = 64;
  localparam int SIZE_ACTIVELIST_LOG = 6;

  typedef logic [CHECKPOINTS-1:0] branchMaskT;  // one bit per live checkpoint

  // instruction as it leaves rename
  typedef struct packed {
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic                         isCtrl;
    logic                         isStore;
    logic                         isLoad;
    branchMaskT                   branchMask;   // older unresolved branches
    logic [CHECKPOINTS_LOG-1:0]   ckptId;       // own checkpoint if isCtrl
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic                         src1Valid;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic                         src2Valid;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhyDest;   // freed at retire
    logic                         oldDestValid;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic                         destValid;
    logic [SIZE_IMMEDIATE-1:0]    immed;
    logic                         immedValid;
    logic [LDST_TYPES_LOG-1:0]    ldstType;
    logic [INST_TYPES_LOG-1:0]    instType;
    logic [SIZE_OPCODE-1:0]       opcode;
    logic [SIZE_PC-1:0]           nextPc;
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_CTI_LOG-1:0]      ctiTag;
  } renamedPktT;

  // issue queue entry
  // same layout as the renamed packet, only branchMask differs in value
  typedef renamedPktT issuePktT;

  // active list entry, enough to retire or roll back the mapping
  typedef struct packed {
    logic                         isLoad;
    logic                         isStore;
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic                         destValid;
  } alPktT;

  // load-store queue allocation info
  typedef struct packed {
    branchMaskT                   branchMask;
    logic                         isStore;
    logic                         isLoad;
  } lsqPktT;

endpackage

/* hw/capacityCheck.sv */
//------------------------------------------------------------
// group capacity check
// load and store counts over the dispatch group
// occupancy plus incoming against LQ, SQ, IQ and active list
//------------------------------------------------------------
module capacityCheck
  import dispatchPkg::*;
(
  input  logic                         clk,
  input  logic                         arstN_i,
  input  renamedPktT                   renamedPkt_i [DISPATCH_WIDTH],
  input  logic [SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  output logic                         stall_o
);

  logic [DISPATCH_WIDTH_LOG-1:0]    loadCnt;
  logic [DISPATCH_WIDTH_LOG-1:0]    storeCnt;

  // one extra bit so the sums cannot wrap
  logic [SIZE_LSQ_LOG+1:0]          loadSum;
  logic [SIZE_LSQ_LOG+1:0]          storeSum;
  logic [SIZE_ISSUEQ_LOG+1:0]       issueSum;
  logic [SIZE_ACTIVELIST_LOG+1:0]   alSum;

  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      loadCnt  = loadCnt + DISPATCH_WIDTH_LOG'(renamedPkt_i[i].isLoad);
      storeCnt = storeCnt + DISPATCH_WIDTH_LOG'(renamedPkt_i[i].isStore);
    end
  end

  // LQ and SQ take only the memory ops, IQ and AL take every slot
  assign loadSum  = (SIZE_LSQ_LOG+2)'(loadQueueCnt_i) + (SIZE_LSQ_LOG+2)'(loadCnt);
  assign storeSum = (SIZE_LSQ_LOG+2)'(storeQueueCnt_i) + (SIZE_LSQ_LOG+2)'(storeCnt);
  assign issueSum = (SIZE_ISSUEQ_LOG+2)'(issueQueueCnt_i)
                  + (SIZE_ISSUEQ_LOG+2)'(DISPATCH_WIDTH);
  assign alSum    = (SIZE_ACTIVELIST_LOG+2)'(activeListCnt_i)
                  + (SIZE_ACTIVELIST_LOG+2)'(DISPATCH_WIDTH);

  assign stall_o = (loadSum  > (SIZE_LSQ_LOG+2)'(SIZE_LSQ))
                 | (storeSum > (SIZE_LSQ_LOG+2)'(SIZE_LSQ))
                 | (issueSum > (SIZE_ISSUEQ_LOG+2)'(SIZE_ISSUEQ))
                 | (alSum    > (SIZE_ACTIVELIST_LOG+2)'(SIZE_ACTIVELIST));

  // decode never marks an instruction as both load and store
  for (genvar g = 0; g < DISPATCH_WIDTH; g++)
  begin : gLdStExcl
    assert property (@(posedge clk) disable iff (!arstN_i)
      !(renamedPkt_i[g].isLoad && renamedPkt_i[g].isStore))
      else $error("capacityCheck: lane %0d is both load and store", g);
  end

  // back-end counters stay within their structure
  assert property (@(posedge clk) disable iff (!arstN_i)
    (loadQueueCnt_i <= SIZE_LSQ) && (storeQueueCnt_i <= SIZE_LSQ)
    && (issueQueueCnt_i <= SIZE_ISSUEQ) && (activeListCnt_i <= SIZE_ACTIVELIST))
    else $error("capacityCheck: occupancy count above structure size");

endmodule

/* hw/dispatchLane.sv */
//------------------------------------------------------------
// one dispatch lane
// clears the verified branch bit from the instruction mask
// splits the instruction into issue, active-list and LSQ packets
//------------------------------------------------------------
module dispatchLane
  import dispatchPkg::*;
(
  input  logic                       clk,
  input  logic                       arstN_i,
  input  logic                       ctrlVerified_i,     // branch resolved correctly
  input  logic [CHECKPOINTS_LOG-1:0] ctrlVerifiedId_i,
  input  renamedPktT                 renamedPkt_i,
  output issuePktT                   issuePkt_o,
  output alPktT                      alPkt_o,
  output lsqPktT                     lsqPkt_o,
  output branchMaskT                 updatedBranchMask_o
);

  branchMaskT clearMask;
  branchMaskT branchMask;

  // one-hot of the checkpoint being freed, empty when nothing verified
  assign clearMask  = ctrlVerified_i ? (branchMaskT'(1) << ctrlVerifiedId_i) : '0;
  assign branchMask = renamedPkt_i.branchMask & ~clearMask;

  // a stalled group stays in the pipeline register, so it needs the new mask too
  assign updatedBranchMask_o = branchMask;

  always_comb
  begin
    issuePkt_o            = renamedPkt_i;
    issuePkt_o.branchMask = branchMask;  // only field that changes
  end

  always_comb
  begin
    alPkt_o.isLoad     = renamedPkt_i.isLoad;
    alPkt_o.isStore    = renamedPkt_i.isStore;
    alPkt_o.pc         = renamedPkt_i.pc;
    alPkt_o.logDest    = renamedPkt_i.logDest;
    alPkt_o.phyDest    = renamedPkt_i.phyDest;
    alPkt_o.oldPhyDest = renamedPkt_i.oldPhyDest;  // released at commit
    alPkt_o.destValid  = renamedPkt_i.destValid;
  end

  // LSQ needs the mask to squash on a mispredict
  always_comb
  begin
    lsqPkt_o.branchMask = branchMask;
    lsqPkt_o.isStore    = renamedPkt_i.isStore;
    lsqPkt_o.isLoad     = renamedPkt_i.isLoad;
  end

  // the mask lists older branches only, never the instruction's own checkpoint
  assert property (@(posedge clk) disable iff (!arstN_i)
    renamedPkt_i.isCtrl |-> !renamedPkt_i.branchMask[renamedPkt_i.ckptId])
    else $error("dispatchLane: control instruction carries its own checkpoint bit");

endmodule

/* hw/dispatch.sv */
//------------------------------------------------------------
// dispatch stage top
// four dispatch lanes, one per instruction in the group
// group capacity check against LQ, SQ, IQ and active list
// back-end ready and front-end stall levels
//------------------------------------------------------------
module dispatch
  import dispatchPkg::*;
(
  input  logic                         clk,
  input  logic                         arstN_i,
  input  logic                         renameReady_i,    // rename holds a full group
  input  logic                         flagRecoverEX_i,  // misprediction recovery
  input  logic                         ctrlVerified_i,
  input  logic [CHECKPOINTS_LOG-1:0]   ctrlVerifiedId_i,
  input  renamedPktT                   renamedPkt_i [DISPATCH_WIDTH],

  // current occupancy of each back-end structure
  input  logic [SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [SIZE_ACTIVELIST_LOG:0] activeListCnt_i,

  output issuePktT                     issuePkt_o [DISPATCH_WIDTH],
  output alPktT                        alPkt_o [DISPATCH_WIDTH],
  output lsqPktT                       lsqPkt_o [DISPATCH_WIDTH],
  // to rename/dispatch reg
  output branchMaskT                   updatedBranchMask_o [DISPATCH_WIDTH],

  output logic                         backEndReady_o,
  output logic                         stallFrontEnd_o
);

  logic groupStall;  // some structure cannot take the whole group

  // every lane sees the same verified checkpoint
  for (genvar g = 0; g < DISPATCH_WIDTH; g++)
  begin : gLane
    dispatchLane u_lane (
      .clk                 (clk),
      .arstN_i             (arstN_i),
      .ctrlVerified_i      (ctrlVerified_i),
      .ctrlVerifiedId_i    (ctrlVerifiedId_i),
      .renamedPkt_i        (renamedPkt_i[g]),
      .issuePkt_o          (issuePkt_o[g]),
      .alPkt_o             (alPkt_o[g]),
      .lsqPkt_o            (lsqPkt_o[g]),
      .updatedBranchMask_o (updatedBranchMask_o[g])
    );
  end

  capacityCheck u_capacityCheck (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .renamedPkt_i    (renamedPkt_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stall_o         (groupStall)
  );

  // the group is all or nothing, so a stall holds decode and rename too
  assign stallFrontEnd_o = groupStall;

  // sampled by rename and the queues at the next clock edge
  assign backEndReady_o  = ~groupStall & renameReady_i & ~flagRecoverEX_i;

endmodule

/* dv/dispatchRef.svh */
//------------------------------------------------------------
// reference model for one dispatch group
// expected branch mask, issue, active-list and LSQ packets
// expected group stall and back-end ready level
//------------------------------------------------------------
`ifndef DISPATCH_REF_SVH
`define DISPATCH_REF_SVH

// verified checkpoint drops out of every younger mask
function automatic branchMaskT refMask(input branchMaskT mask, input logic verified,
                                       input logic [CHECKPOINTS_LOG-1:0] id);
  branchMaskT r;
  r = mask;
  if (verified)
    r[id] = 1'b0;
  return r;
endfunction

function automatic issuePktT refIssue(input renamedPktT p, input logic verified,
                                      input logic [CHECKPOINTS_LOG-1:0] id);
  issuePktT r;
  r = p;  // everything else passes through untouched
  r.branchMask = refMask(p.branchMask, verified, id);
  return r;
endfunction

function automatic alPktT refAl(input renamedPktT p);
  alPktT r;
  r.isLoad     = p.isLoad;
  r.isStore    = p.isStore;
  r.pc         = p.pc;
  r.logDest    = p.logDest;
  r.phyDest    = p.phyDest;
  r.oldPhyDest = p.oldPhyDest;
  r.destValid  = p.destValid;
  return r;
endfunction

function automatic lsqPktT refLsq(input renamedPktT p, input logic verified,
                                  input logic [CHECKPOINTS_LOG-1:0] id);
  lsqPktT r;
  r.branchMask = refMask(p.branchMask, verified, id);
  r.isStore    = p.isStore;
  r.isLoad     = p.isLoad;
  return r;
endfunction

// stall when any structure would overflow with the whole group
function automatic logic refStall(input renamedPktT pkts [DISPATCH_WIDTH],
                                  input int lq, input int sq, input int iq, input int al);
  int loads;
  int stores;
  loads  = 0;
  stores = 0;
  for (int i = 0; i < DISPATCH_WIDTH; i++)
  begin
    if (pkts[i].isLoad)
      loads++;
    if (pkts[i].isStore)
      stores++;
  end
  return (lq + loads > SIZE_LSQ) || (sq + stores > SIZE_LSQ)
      || (iq + DISPATCH_WIDTH > SIZE_ISSUEQ) || (al + DISPATCH_WIDTH > SIZE_ACTIVELIST);
endfunction

function automatic logic refReady(input logic stall, input logic ready, input logic recover);
  return !stall && ready && !recover;
endfunction

`endif

/* dv/dispatchTb.sv */
//------------------------------------------------------------
// testbench for the dispatch stage
// clock, reset and random group stimulus per test
// negedge compare process against the reference model
// per-test result lines, closing counts and watchdog
//------------------------------------------------------------
module dispatchTb
  import dispatchPkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int TEST_VECS     = 64;
  localparam int READY_VECS    = 32;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 4 * TEST_VECS + READY_VECS + 10;
  localparam int WATCHDOG_TIME = TOTAL_CYCLES * CLK_PERIOD + 200;

  logic                         clk;
  logic                         arstN;
  logic                         renameReady;
  logic                         flagRecoverEX;
  logic                         ctrlVerified;
  logic [CHECKPOINTS_LOG-1:0]   ctrlVerifiedId;
  renamedPktT                   renamedPkt [DISPATCH_WIDTH];
  logic [SIZE_LSQ_LOG:0]        loadQueueCnt;
  logic [SIZE_LSQ_LOG:0]        storeQueueCnt;
  logic [SIZE_ISSUEQ_LOG:0]     issueQueueCnt;
  logic [SIZE_ACTIVELIST_LOG:0] activeListCnt;
  issuePktT                     issuePkt [DISPATCH_WIDTH];
  alPktT                        alPkt [DISPATCH_WIDTH];
  lsqPktT                       lsqPkt [DISPATCH_WIDTH];
  branchMaskT                   updatedBranchMask [DISPATCH_WIDTH];
  logic                         backEndReady;
  logic                         stallFrontEnd;

  integer seed = 93292;
  logic   checkEn;        // set once the first group is on the inputs
  int     checksDone = 0;
  int     errCount = 0;
  int     passCount = 0;
  int     failCount = 0;

  `include "dispatchRef.svh"

  dispatch u_dispatch (
    .clk                 (clk),
    .arstN_i             (arstN),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedPkt_i        (renamedPkt),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .issuePkt_o          (issuePkt),
    .alPkt_o             (alPkt),
    .lsqPkt_o            (lsqPkt),
    .updatedBranchMask_o (updatedBranchMask),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic randCount(input int lo, input int hi, output int cnt);
    logic [31:0] rnd;
    rnd = $random(seed);
    cnt = lo + int'(rnd[15:0]) % (hi - lo + 1);
  endtask

  // three in four counts land within 8 of full
  task automatic nearFull(input int size, output int cnt);
    logic [31:0] rnd;
    rnd = $random(seed);
    if (rnd[1:0] != 2'b00)
      randCount(size - 8, size, cnt);
    else
      randCount(0, size, cnt);
  endtask

  // random instruction, never both load and store
  task automatic makePkt(output renamedPktT p);
    logic [159:0] bits;
    logic [31:0]  kind;
    bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    p    = bits[$bits(renamedPktT)-1:0];
    kind = $random(seed);
    case (kind[1:0])
      2'd0:
      begin
        p.isLoad  = 1'b1;
        p.isStore = 1'b0;
      end
      2'd1:
      begin
        p.isLoad  = 1'b0;
        p.isStore = 1'b1;
      end
      default:
      begin
        p.isLoad  = 1'b0;
        p.isStore = 1'b0;
      end
    endcase
    if (p.isCtrl)
      p.branchMask[p.ckptId] = 1'b0;  // a branch is not younger than itself
  endtask

  task automatic driveVector(input int testId, input int v);
    renamedPktT  pkts [DISPATCH_WIDTH];
    logic [31:0] rnd;
    int          loads;
    int          stores;
    int          lq;
    int          sq;
    int          iq;
    int          al;
    loads  = 0;
    stores = 0;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      makePkt(pkts[i]);
      loads  = loads + (pkts[i].isLoad ? 1 : 0);
      stores = stores + (pkts[i].isStore ? 1 : 0);
    end
    rnd = $random(seed);
    nearFull(SIZE_LSQ, lq);
    nearFull(SIZE_LSQ, sq);
    nearFull(SIZE_ISSUEQ, iq);
    nearFull(SIZE_ACTIVELIST, al);
    if (testId == 3)
    begin
      if (v < 16)
      begin
        lq = SIZE_LSQ - loads + (v % 2);  // exactly full, then one over
        sq = SIZE_LSQ - stores + ((v / 2) % 2);
        if (lq > SIZE_LSQ)
          lq = SIZE_LSQ;
        if (sq > SIZE_LSQ)
          sq = SIZE_LSQ;
      end
      randCount(0, SIZE_ISSUEQ - DISPATCH_WIDTH, iq);
      randCount(0, SIZE_ACTIVELIST - DISPATCH_WIDTH, al);
    end
    else if (testId == 4)
    begin
      randCount(0, SIZE_LSQ - DISPATCH_WIDTH, lq);
      randCount(0, SIZE_LSQ - DISPATCH_WIDTH, sq);
      if (v < 4)
      begin
        iq = SIZE_ISSUEQ - DISPATCH_WIDTH + (v % 2);  // 28 and 29
        randCount(0, SIZE_ACTIVELIST - DISPATCH_WIDTH, al);
      end
      else if (v < 8)
      begin
        al = SIZE_ACTIVELIST - DISPATCH_WIDTH + (v % 2);  // 60 and 61
        randCount(0, SIZE_ISSUEQ - DISPATCH_WIDTH, iq);
      end
    end
    else if (testId == 5 && v < 8)
    begin
      lq = 0;
      sq = 0;
      al = 0;
      iq = v[2] ? SIZE_ISSUEQ : 0;  // forced stall or clear
    end
    @(posedge clk);
    for (int i = 0; i < DISPATCH_WIDTH; i++)
      renamedPkt[i] <= pkts[i];
    ctrlVerified   <= (testId == 1) ? 1'b0 : ((testId == 2) ? 1'b1 : rnd[0]);
    ctrlVerifiedId <= rnd[3:1];
    renameReady    <= (testId == 5 && v < 8) ? v[0] : rnd[4];
    flagRecoverEX  <= (testId == 5 && v < 8) ? v[1] : rnd[5];
    loadQueueCnt   <= (SIZE_LSQ_LOG+1)'(lq);
    storeQueueCnt  <= (SIZE_LSQ_LOG+1)'(sq);
    issueQueueCnt  <= (SIZE_ISSUEQ_LOG+1)'(iq);
    activeListCnt  <= (SIZE_ACTIVELIST_LOG+1)'(al);
    checkEn        <= 1'b1;
  endtask

  task automatic reportMismatch(input string sigName, input logic [159:0] expVal,
                                input logic [159:0] actVal);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, sigName, expVal, actVal);
    errCount++;
  endtask

  task automatic checkGroup();
    branchMaskT expMask;
    issuePktT   expIssue;
    alPktT      expAl;
    lsqPktT     expLsq;
    logic       expStall;
    logic       expReady;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      expMask  = refMask(renamedPkt[i].branchMask, ctrlVerified, ctrlVerifiedId);
      expIssue = refIssue(renamedPkt[i], ctrlVerified, ctrlVerifiedId);
      expAl    = refAl(renamedPkt[i]);
      expLsq   = refLsq(renamedPkt[i], ctrlVerified, ctrlVerifiedId);
      assert (updatedBranchMask[i] === expMask)
        else reportMismatch($sformatf("updatedBranchMask_o[%0d]", i), 160'(expMask),
                            160'(updatedBranchMask[i]));
      assert (issuePkt[i] === expIssue)
        else reportMismatch($sformatf("issuePkt_o[%0d]", i), 160'(expIssue),
                            160'(issuePkt[i]));
      assert (alPkt[i] === expAl)
        else reportMismatch($sformatf("alPkt_o[%0d]", i), 160'(expAl), 160'(alPkt[i]));
      assert (lsqPkt[i] === expLsq)
        else reportMismatch($sformatf("lsqPkt_o[%0d]", i), 160'(expLsq), 160'(lsqPkt[i]));
    end
    expStall = refStall(renamedPkt, int'(loadQueueCnt), int'(storeQueueCnt),
                        int'(issueQueueCnt), int'(activeListCnt));
    expReady = refReady(expStall, renameReady, flagRecoverEX);
    assert (stallFrontEnd === expStall)
      else reportMismatch("stallFrontEnd_o", 160'(expStall), 160'(stallFrontEnd));
    assert (backEndReady === expReady)
      else reportMismatch("backEndReady_o", 160'(expReady), 160'(backEndReady));
  endtask

  // outputs settle half a cycle after the rising-edge drive
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (checkEn)
      begin
        checkGroup();
        checksDone = checksDone + 1;
      end
    end
  end

  task automatic runTest(input int testId, input string name, input int nVec);
    int target;
    int errBefore;
    errBefore = errCount;
    target    = checksDone + nVec;
    for (int v = 0; v < nVec; v++)
      driveVector(testId, v);
    wait (checksDone >= target);
    if (errCount == errBefore)
    begin
      passCount++;
      $display("test %0d %s: ok, %0d groups checked", testId, name, nVec);
    end
    else
    begin
      failCount++;
      $display("test %0d %s: %0d mismatches", testId, name, errCount - errBefore);
    end
  endtask

  initial
  begin
    arstN          <= 1'b0;
    renameReady    <= 1'b0;
    flagRecoverEX  <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlVerifiedId <= '0;
    loadQueueCnt   <= '0;
    storeQueueCnt  <= '0;
    issueQueueCnt  <= '0;
    activeListCnt  <= '0;
    checkEn        <= 1'b0;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
      renamedPkt[i] <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;

    runTest(1, "packet split", TEST_VECS);
    runTest(2, "branch mask clear", TEST_VECS);
    runTest(3, "load/store capacity", TEST_VECS);
    runTest(4, "issue queue and active list capacity", TEST_VECS);
    runTest(5, "ready level", READY_VECS);

    $display("tests passed %0d, failed %0d, mismatches %0d", passCount, failCount, errCount);
    if (failCount == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("watchdog: run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* build.f */
+incdir+dv
common/dispatchPkg.sv
hw/capacityCheck.sv
hw/dispatchLane.sv
hw/dispatch.sv
dv/dispatchTb.sv

/* Makefile */
SIM      := verilator
TOP      := dispatchTb
FILELIST := build.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := dv/dispatchRef.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^Simulation PASSED$$'

clean:
	rm -rf $(OBJDIR)
